// File: imem_wb_bridge.f
verilog/imem_pkg.sv
verilog/sync_fifo.sv
verilog/imem_req_stage.sv
verilog/imem_wb_master.sv
verilog/imem_resp_stage.sv
verilog/imem_wb_bridge.sv
tb/wb_mem_model.sv
tb/tb_imem_wb_bridge.sv

// File: tb/tb_imem_wb_bridge.sv
/*
 * Testbench for the instruction-fetch Wishbone bridge.
 * Drives fetches on the core side, checks every response against a
 * reference model of the slave, and watches the bus for misaligned cycles.
 */
`timescale 1ns/1ns

module tb_imem_wb_bridge;

    import imem_pkg::*;

    localparam logic [31:0] DATA_PATTERN = 32'h5A3C_96E1;
    localparam int N_TOTAL  = 4 + 20 + 4 + 4 + 40;
    localparam int WD_LIMIT = N_TOTAL * 12 + 200;

    // Core and bus outputs right after reset
    localparam logic [68:0] RST_EXP = {1'b1, 1'b0, 1'b0, 32'h0, IMEM_RESP_NOTRDY, 32'h0};

    logic                     core_clk;
    logic                     reset_i;
    logic                     imem_req_i;
    logic [IMEM_WB_WIDTH-1:0] imem_addr_i;
    logic                     imem_req_ack_o;
    imem_resp_e               imem_resp_o;
    logic [IMEM_WB_WIDTH-1:0] imem_rdata_o;
    logic                     wbd_cyc_o;
    logic                     wbd_stb_o;
    logic [IMEM_WB_WIDTH-1:0] wbd_adr_o;
    logic [IMEM_WB_WIDTH-1:0] wbd_dat_i;
    logic                     wbd_ack_i;
    logic                     wbd_err_i;

    // Accepted addresses in order, plus bookkeeping
    logic [31:0] exp_q[$];
    logic [31:0] rnd;
    logic [31:0] cmp_addr;
    logic [33:0] cmp_exp;
    logic [68:0] rst_act;
    logic        ack_low_seen;
    string       cur_test;
    int          err_cnt;
    int          test_err_base;
    int          test_cnt;
    int          test_fail;
    int          req_cnt;
    int          resp_cnt;

    imem_wb_bridge imem_wb_bridge_inst (.*);

    wb_mem_model #(.PATTERN(DATA_PATTERN), .SEED(32'd84)) u_mem (
        .clk_i(core_clk), .reset_i(reset_i), .wbd_cyc_i(wbd_cyc_o), .wbd_stb_i(wbd_stb_o),
        .wbd_adr_i(wbd_adr_o), .wbd_dat_o(wbd_dat_i), .wbd_ack_o(wbd_ack_i),
        .wbd_err_o(wbd_err_i)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected {code, data}, misaligned or error region gives zero data
    function automatic logic [33:0] expect_resp(input logic [31:0] a);
        if (a[1:0] != 2'b00 || a[15]) begin
            return {IMEM_RESP_RDY_ER, 32'h0};
        end
        return {IMEM_RESP_RDY_OK, a ^ DATA_PATTERN};
    endfunction

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    // Watchdog sized from the request count
    initial begin
        repeat (WD_LIMIT) @(posedge core_clk);
        $display("Timeout: %0d cycles passed, %0d fetches still pending", WD_LIMIT, exp_q.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    // -------------------------------------------------------------------
    // Comparison at mid-cycle, where all DUT outputs are stable
    // -------------------------------------------------------------------
    always @(negedge core_clk) begin
        if (!reset_i) begin
            if (!imem_req_ack_o) ack_low_seen = 1'b1;
            // Queue size matches the DUT's outstanding count here
            if (exp_q.size() == IMEM_MAX_OUTSTANDING && imem_req_ack_o) begin
                $display("Error %s: request ack high with the outstanding limit reached", cur_test);
                err_cnt++;
            end
            // Classic bus, stb always travels with cyc
            if (wbd_stb_o !== wbd_cyc_o) begin
                $display("Error %s: wbd_stb_o expected %b, actual %b", cur_test, wbd_cyc_o,
                         wbd_stb_o);
                err_cnt++;
            end
            if (wbd_cyc_o && wbd_adr_o[1:0] != 2'b00) begin
                $display("Error %s: bus cycle started on misaligned address %h", cur_test, wbd_adr_o);
                err_cnt++;
            end
            if (imem_resp_o != IMEM_RESP_NOTRDY) begin
                resp_cnt++;
                if (exp_q.size() == 0) begin
                    $display("Error %s: response arrived with no fetch pending", cur_test);
                    err_cnt++;
                end else begin
                    cmp_addr = exp_q.pop_front();
                    cmp_exp  = expect_resp(cmp_addr);
                    if ({imem_resp_o, imem_rdata_o} !== cmp_exp) begin
                        $display("Error %s: addr %h expected %h, actual %h", cur_test, cmp_addr,
                                 cmp_exp, {imem_resp_o, imem_rdata_o});
                        err_cnt++;
                    end
                end
            end
        end
    end

    // Called on a rising edge, returns on the accepting edge
    task automatic send(input logic [31:0] a);
        imem_req_i  <= 1'b1;
        imem_addr_i <= a;
        @(posedge core_clk);
        while (!imem_req_ack_o) @(posedge core_clk);
        exp_q.push_back(a);
        req_cnt++;
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = err_cnt;
    endtask

    // Drain, catch stray responses, then one line per test
    task automatic end_test();
        imem_req_i <= 1'b0;
        while (exp_q.size() != 0) @(posedge core_clk);
        repeat (4) @(posedge core_clk);
        if (resp_cnt != req_cnt) begin
            $display("Error %s: expected %0d responses, actual %0d", cur_test, req_cnt, resp_cnt);
            err_cnt++;
        end
        test_cnt++;
        if (err_cnt == test_err_base) begin
            $display("Test %-9s passed", cur_test);
        end else begin
            $display("Test %-9s failed with %0d errors", cur_test, err_cnt - test_err_base);
            test_fail++;
        end
    endtask

    // -------------------------------------------------------------------
    // Test sequence
    // -------------------------------------------------------------------
    initial begin
        reset_i      = 1'b1;
        imem_req_i   = 1'b0;
        imem_addr_i  = '0;
        rnd          = 32'd84;
        ack_low_seen = 1'b0;
        cur_test     = "reset";
        {err_cnt, test_err_base, test_cnt, test_fail, req_cnt, resp_cnt} = '0;
        repeat (2) @(posedge core_clk);
        reset_i <= 1'b0;

        start_test("reset");
        @(negedge core_clk);
        rst_act = {imem_req_ack_o, wbd_cyc_o, wbd_stb_o, wbd_adr_o, imem_resp_o, imem_rdata_o};
        if (rst_act !== RST_EXP) begin
            $display("Error reset: {ack, cyc, stb, adr, resp, rdata} expected %h, actual %h",
                     RST_EXP, rst_act);
            err_cnt++;
        end
        @(posedge core_clk);
        end_test();

        // One fetch at a time
        start_test("single");
        for (int i = 0; i < 4; i++) begin
            send(32'h0000_1000 + i * 4);
            imem_req_i <= 1'b0;
            while (exp_q.size() != 0) @(posedge core_clk);
        end
        end_test();

        start_test("burst");
        ack_low_seen = 1'b0;
        for (int i = 0; i < 20; i++) begin
            rnd = xorshift(rnd);
            send(rnd & 32'hFFFF_7FFC);
        end
        if (!ack_low_seen) begin
            $display("Error burst: request ack never dropped during the burst");
            err_cnt++;
        end
        end_test();

        start_test("bus_err");
        send(32'h0000_8000);
        send(32'h1234_8004);
        send(32'hFFFF_FFFC);
        send(32'h0000_2000);
        end_test();

        start_test("misalign");
        send(32'h0000_3001);
        send(32'h0000_3002);
        send(32'h0000_3003);
        send(32'h0000_3004);
        end_test();

        // Kind picked from two random bits, occasional idle gap
        start_test("mixed");
        for (int i = 0; i < 40; i++) begin
            rnd = xorshift(rnd);
            case (rnd[17:16])
                2'd0:    send((rnd & 32'hFFFF_FFFC) | 32'h0000_8000);
                2'd1:    send((rnd & 32'hFFFF_7FFC) | 32'h1);
                default: send(rnd & 32'hFFFF_7FFC);
            endcase
            if (rnd[20]) begin
                imem_req_i <= 1'b0;
                @(posedge core_clk);
            end
        end
        end_test();

        $display("Tests %0d, failed %0d, fetches %0d, responses %0d, errors %0d",
                 test_cnt, test_fail, req_cnt, resp_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb/wb_mem_model.sv
/*
 * Wishbone classic slave model for the fetch bridge testbench.
 * Answers each cycle after 0 to 3 random wait states with read data
 * equal to the address XOR a fixed pattern. Bit 15 set gives a bus error.
 */
`timescale 1ns/1ns

module wb_mem_model #(
    parameter logic [31:0] PATTERN = 32'h5A3C_96E1,
    parameter logic [31:0] SEED    = 32'd84
) (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               wbd_cyc_i,
    input  logic                               wbd_stb_i,
    input  logic [imem_pkg::IMEM_WB_WIDTH-1:0] wbd_adr_i,
    output logic [imem_pkg::IMEM_WB_WIDTH-1:0] wbd_dat_o,
    output logic                               wbd_ack_o,
    output logic                               wbd_err_o
);

    logic [31:0] rnd_q;
    logic [1:0]  wait_q;    // Wait states still to insert
    logic        busy_q;    // Current cycle already seen

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rnd_q     <= SEED;
            wait_q    <= '0;
            busy_q    <= 1'b0;
            wbd_ack_o <= 1'b0;
            wbd_err_o <= 1'b0;
            wbd_dat_o <= '0;
        end else begin
            // Termination lasts one cycle
            wbd_ack_o <= 1'b0;
            wbd_err_o <= 1'b0;
            wbd_dat_o <= '0;
            if (wbd_cyc_i && wbd_stb_i && !wbd_ack_o && !wbd_err_o) begin
                if (!busy_q) begin
                    // New cycle, draw its wait states
                    rnd_q <= xorshift(rnd_q);
                end
                if (!busy_q && rnd_q[1:0] != 2'd0) begin
                    // First edge already counts as one wait state
                    busy_q <= 1'b1;
                    wait_q <= rnd_q[1:0] - 2'd1;
                end else if (busy_q && wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    // Zero draw terminates on the first edge
                    busy_q <= 1'b0;
                    if (wbd_adr_i[15]) begin
                        wbd_err_o <= 1'b1;
                    end else begin
                        wbd_ack_o <= 1'b1;
                        wbd_dat_o <= wbd_adr_i ^ PATTERN;
                    end
                end
            end
        end
    end

endmodule

// File: verilog/imem_wb_bridge.sv
/*
 * Top level of the read-only instruction-fetch Wishbone bridge.
 * Core fetches flow through a request FIFO to the bus master, results
 * return in order through a response FIFO. Single clock domain.
 */
`timescale 1ns/1ns

module imem_wb_bridge (
    input  logic                               core_clk,
    input  logic                               reset_i,

    // Core side
    input  logic                               imem_req_i,
    input  logic [imem_pkg::IMEM_WB_WIDTH-1:0] imem_addr_i,
    output logic                               imem_req_ack_o,
    output imem_pkg::imem_resp_e               imem_resp_o,
    output logic [imem_pkg::IMEM_WB_WIDTH-1:0] imem_rdata_o,

    // Wishbone side
    output logic                               wbd_cyc_o,
    output logic                               wbd_stb_o,
    output logic [imem_pkg::IMEM_WB_WIDTH-1:0] wbd_adr_o,
    input  logic [imem_pkg::IMEM_WB_WIDTH-1:0] wbd_dat_i,
    input  logic                               wbd_ack_i,
    input  logic                               wbd_err_i
);

    import imem_pkg::*;

    // Request path, entry is {misaligned, addr}
    logic                     req_fifo_wr;
    logic [IMEM_WB_WIDTH:0]   req_fifo_wdata;
    logic                     req_fifo_full;
    logic                     req_fifo_rd;
    logic [IMEM_WB_WIDTH:0]   req_fifo_rdata;
    logic                     req_fifo_empty;

    // Response path, entry is {err, data}
    logic                     resp_fifo_wr;
    logic [IMEM_WB_WIDTH:0]   resp_fifo_wdata;
    logic                     resp_fifo_rd;
    logic [IMEM_WB_WIDTH:0]   resp_fifo_rdata;
    logic                     resp_fifo_empty;
    logic                     resp_delivered;

    // ----------------------------------------------------------------------
    // Request path
    // ----------------------------------------------------------------------
    imem_req_stage u_req_stage (
        .core_clk         (core_clk),
        .reset_i          (reset_i),
        .imem_req_i       (imem_req_i),
        .imem_addr_i      (imem_addr_i),
        .imem_req_ack_o   (imem_req_ack_o),
        .fifo_full_i      (req_fifo_full),
        .fifo_wr_o        (req_fifo_wr),
        .fifo_wdata_o     (req_fifo_wdata),
        .resp_delivered_i (resp_delivered)
    );

    sync_fifo #(.W(IMEM_WB_WIDTH + 1), .DP(IMEM_FIFO_DEPTH)) u_req_fifo (
        .core_clk  (core_clk),
        .reset_i   (reset_i),
        .wr_en_i   (req_fifo_wr),
        .wr_data_i (req_fifo_wdata),
        .full_o    (req_fifo_full),
        .rd_en_i   (req_fifo_rd),
        .rd_data_o (req_fifo_rdata),
        .empty_o   (req_fifo_empty)
    );

    // ----------------------------------------------------------------------
    // Bus master
    // ----------------------------------------------------------------------
    imem_wb_master u_wb_master (
        .core_clk     (core_clk),
        .reset_i      (reset_i),
        .req_empty_i  (req_fifo_empty),
        .req_rdata_i  (req_fifo_rdata),
        .req_rd_o     (req_fifo_rd),
        .resp_wr_o    (resp_fifo_wr),
        .resp_wdata_o (resp_fifo_wdata),
        .wbd_cyc_o    (wbd_cyc_o),
        .wbd_stb_o    (wbd_stb_o),
        .wbd_adr_o    (wbd_adr_o),
        .wbd_dat_i    (wbd_dat_i),
        .wbd_ack_i    (wbd_ack_i),
        .wbd_err_i    (wbd_err_i)
    );

    // ----------------------------------------------------------------------
    // Response path
    // ----------------------------------------------------------------------

    // Outstanding limit keeps this FIFO from filling up
    sync_fifo #(.W(IMEM_WB_WIDTH + 1), .DP(IMEM_FIFO_DEPTH)) u_resp_fifo (
        .core_clk  (core_clk),
        .reset_i   (reset_i),
        .wr_en_i   (resp_fifo_wr),
        .wr_data_i (resp_fifo_wdata),
        .full_o    (),
        .rd_en_i   (resp_fifo_rd),
        .rd_data_o (resp_fifo_rdata),
        .empty_o   (resp_fifo_empty)
    );

    imem_resp_stage u_resp_stage (
        .core_clk         (core_clk),
        .reset_i          (reset_i),
        .resp_empty_i     (resp_fifo_empty),
        .resp_rdata_i     (resp_fifo_rdata),
        .resp_rd_o        (resp_fifo_rd),
        .resp_delivered_o (resp_delivered),
        .imem_resp_o      (imem_resp_o),
        .imem_rdata_o     (imem_rdata_o)
    );

endmodule

// File: verilog/imem_resp_stage.sv
/*
 * Response stage of the fetch bridge.
 * Pops every available response entry and presents it to the core for
 * exactly one cycle as a registered response code and read data.
 */
`timescale 1ns/1ns

module imem_resp_stage (
    input  logic                               core_clk,
    input  logic                               reset_i,

    // Response FIFO read side
    input  logic                               resp_empty_i,
    input  logic [imem_pkg::IMEM_WB_WIDTH:0]   resp_rdata_i,
    output logic                               resp_rd_o,

    // Back to the request stage
    output logic                               resp_delivered_o,

    // Core response
    output imem_pkg::imem_resp_e               imem_resp_o,
    output logic [imem_pkg::IMEM_WB_WIDTH-1:0] imem_rdata_o
);

    import imem_pkg::*;

    // No back-pressure from the core, drain whenever data is there
    assign resp_rd_o = !resp_empty_i;

    // ----------------------------------------------------------------------
    // Core response register
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            imem_resp_o  <= IMEM_RESP_NOTRDY;
            imem_rdata_o <= '0;
        end else if (resp_rd_o) begin
            // Entry MSB is the error flag
            imem_resp_o  <= resp_rdata_i[IMEM_WB_WIDTH] ? IMEM_RESP_RDY_ER
                                                        : IMEM_RESP_RDY_OK;
            imem_rdata_o <= resp_rdata_i[IMEM_WB_WIDTH-1:0];
        end else begin
            // Quiet cycle
            imem_resp_o  <= IMEM_RESP_NOTRDY;
            imem_rdata_o <= '0;
        end
    end

    // One pulse per response seen by the core
    assign resp_delivered_o = (imem_resp_o != IMEM_RESP_NOTRDY);

endmodule

// File: verilog/imem_wb_master.sv
/*
 * Wishbone classic read master for the fetch bridge.
 * Pops request entries, runs one bus cycle per aligned entry and writes
 * {err, data} into the response FIFO. Misaligned entries skip the bus.
 */
`timescale 1ns/1ns

module imem_wb_master (
    input  logic                               core_clk,
    input  logic                               reset_i,

    // Request FIFO read side
    input  logic                               req_empty_i,
    input  logic [imem_pkg::IMEM_WB_WIDTH:0]   req_rdata_i,
    output logic                               req_rd_o,

    // Response FIFO write side
    output logic                               resp_wr_o,
    output logic [imem_pkg::IMEM_WB_WIDTH:0]   resp_wdata_o,

    // Wishbone bus
    output logic                               wbd_cyc_o,
    output logic                               wbd_stb_o,
    output logic [imem_pkg::IMEM_WB_WIDTH-1:0] wbd_adr_o,
    input  logic [imem_pkg::IMEM_WB_WIDTH-1:0] wbd_dat_i,
    input  logic                               wbd_ack_i,
    input  logic                               wbd_err_i
);

    import imem_pkg::*;

    wb_state_e                  state_q;
    logic                       mis_pend_q;     // Error entry owed next cycle
    logic                       bus_done;
    logic                       req_mis;
    logic [IMEM_WB_WIDTH-1:0]   req_addr;

    // Unpack request entry
    assign req_mis  = req_rdata_i[IMEM_WB_WIDTH];
    assign req_addr = req_rdata_i[IMEM_WB_WIDTH-1:0];

    // Pop in the cycle the master leaves idle
    assign req_rd_o = (state_q == WB_IDLE) && !req_empty_i;

    // Slave termination, ack or err
    assign bus_done = (state_q == WB_BUSY) && (wbd_ack_i || wbd_err_i);

    // ----------------------------------------------------------------------
    // Bus state machine
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            state_q    <= WB_IDLE;
            mis_pend_q <= 1'b0;
            wbd_cyc_o  <= 1'b0;
            wbd_stb_o  <= 1'b0;
            wbd_adr_o  <= '0;
        end else begin
            // Misaligned pop, answer one cycle later
            mis_pend_q <= req_rd_o && req_mis;

            case (state_q)
                WB_IDLE: begin
                    if (req_rd_o && !req_mis) begin
                        state_q   <= WB_BUSY;
                        wbd_cyc_o <= 1'b1;
                        wbd_stb_o <= 1'b1;
                        // Address held stable for the whole cycle
                        wbd_adr_o <= req_addr;
                    end
                end
                WB_BUSY: begin
                    // Drop cyc/stb right after termination, no pipelining
                    if (bus_done) begin
                        state_q   <= WB_IDLE;
                        wbd_cyc_o <= 1'b0;
                        wbd_stb_o <= 1'b0;
                    end
                end
                default: begin
                    state_q <= WB_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Response entry
    // ----------------------------------------------------------------------

    // Written on the same edge that samples ack or err
    assign resp_wr_o = bus_done || mis_pend_q;

    // Never overlaps, mis_pend_q is only set out of idle
    always_comb begin
        if (mis_pend_q) begin
            resp_wdata_o = {1'b1, {IMEM_WB_WIDTH{1'b0}}};
        end else if (wbd_err_i) begin
            // Err wins over ack, data zeroed
            resp_wdata_o = {1'b1, {IMEM_WB_WIDTH{1'b0}}};
        end else begin
            resp_wdata_o = {1'b0, wbd_dat_i};
        end
    end

endmodule

// File: verilog/imem_req_stage.sv
/*
 * Request stage of the fetch bridge.
 * Accepts core fetches into the request FIFO, tags misaligned addresses
 * and holds off the core once the outstanding limit is reached.
 */
`timescale 1ns/1ns

module imem_req_stage (
    input  logic                               core_clk,
    input  logic                               reset_i,

    // Core request
    input  logic                               imem_req_i,
    input  logic [imem_pkg::IMEM_WB_WIDTH-1:0] imem_addr_i,
    output logic                               imem_req_ack_o,

    // Request FIFO write side
    input  logic                               fifo_full_i,
    output logic                               fifo_wr_o,
    output logic [imem_pkg::IMEM_WB_WIDTH:0]   fifo_wdata_o,

    // One pulse per response handed to the core
    input  logic                               resp_delivered_i
);

    import imem_pkg::*;

    // Fetches accepted but not yet delivered
    logic [$clog2(IMEM_MAX_OUTSTANDING+1)-1:0] out_cnt_q;
    logic                                      misaligned;

    // Back-pressure from FIFO space and in-flight limit
    assign imem_req_ack_o = !fifo_full_i && (out_cnt_q < IMEM_MAX_OUTSTANDING);
    assign fifo_wr_o      = imem_req_i && imem_req_ack_o;

    // Word fetches only, any low address bit set is an error
    assign misaligned   = |imem_addr_i[1:0];
    assign fifo_wdata_o = {misaligned, imem_addr_i};

    // ----------------------------------------------------------------------
    // Outstanding counter
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            out_cnt_q <= '0;
        end else begin
            // Accept and deliver in one cycle leaves the count alone
            if (fifo_wr_o && !resp_delivered_i) begin
                out_cnt_q <= out_cnt_q + 1'b1;
            end else if (resp_delivered_i && !fifo_wr_o) begin
                out_cnt_q <= out_cnt_q - 1'b1;
            end
        end
    end

endmodule

// File: verilog/sync_fifo.sv
/*
 * Single-clock register-array FIFO with registered full and empty flags.
 * Used on both the request and the response path of the bridge.
 * Read data shows the head entry, or zero while the FIFO is empty.
 */
`timescale 1ns/1ns

module sync_fifo #(
    parameter int W  = 8,   // Entry width
    parameter int DP = 4    // Entry count
) (
    input  logic         core_clk,
    input  logic         reset_i,

    // Write side
    input  logic         wr_en_i,
    input  logic [W-1:0] wr_data_i,
    output logic         full_o,

    // Read side
    input  logic         rd_en_i,
    output logic [W-1:0] rd_data_o,
    output logic         empty_o
);

    // Storage, no reset needed
    logic [W-1:0]               mem [DP];

    logic [$clog2(DP)-1:0]      wr_ptr_q;
    logic [$clog2(DP)-1:0]      rd_ptr_q;
    logic [$clog2(DP+1)-1:0]    cnt_q;
    logic [$clog2(DP+1)-1:0]    cnt_nxt;
    logic                       do_wr;
    logic                       do_rd;

    // Guard against overflow and underflow
    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd_en_i && !empty_o;

    // Occupancy after this edge
    always_comb begin
        cnt_nxt = cnt_q;
        if (do_wr && !do_rd) begin
            cnt_nxt = cnt_q + 1'b1;
        end else if (do_rd && !do_wr) begin
            cnt_nxt = cnt_q - 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Pointers, count and flags
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            full_o   <= 1'b0;
            empty_o  <= 1'b1;
        end else begin
            if (do_wr) begin
                // Wrap at depth, DP need not be a power of two
                wr_ptr_q <= (wr_ptr_q == DP - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= (rd_ptr_q == DP - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q   <= cnt_nxt;
            full_o  <= (cnt_nxt == DP);
            empty_o <= (cnt_nxt == 0);
        end
    end

    // Storage write
    always_ff @(posedge core_clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    // Zero while empty, keeps X out of downstream logic after reset
    assign rd_data_o = empty_o ? '0 : mem[rd_ptr_q];

endmodule

// File: verilog/imem_pkg.sv
/*
 * Shared constants and types for the instruction-fetch Wishbone bridge.
 * Imported by every bridge module that needs bus widths, FIFO sizing,
 * the core response code or the bus master state.
 */
package imem_pkg;

    // ----------------------------------------------------------------------
    // Sizing
    // ----------------------------------------------------------------------

    // Address and data width, core and bus side alike
    localparam int IMEM_WB_WIDTH = 32;

    // Entries in each of the request and response FIFOs
    localparam int IMEM_FIFO_DEPTH = 4;

    // Fetches held between acceptance and delivery
    // Same as FIFO depth so the response FIFO never overflows
    localparam int IMEM_MAX_OUTSTANDING = IMEM_FIFO_DEPTH;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------

    // Core response code
    typedef enum logic [1:0] {
        IMEM_RESP_NOTRDY = 2'b00,   // No response this cycle
        IMEM_RESP_RDY_OK = 2'b01,   // Read data valid
        IMEM_RESP_RDY_ER = 2'b10    // Bus error or misaligned fetch
    } imem_resp_e;

    // Wishbone master bus state
    typedef enum logic {
        WB_IDLE = 1'b0,             // Waiting for a request entry
        WB_BUSY = 1'b1              // cyc/stb held until ack or err
    } wb_state_e;

    // Request entry is {misaligned, addr}
    // Response entry is {err, data}
    // Both packed by concatenation at the FIFO ports

endpackage
